// ==== run_sim.sh ====
#!/bin/sh
# build the traceback testbench with Verilator and run it
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module traceback_tb \
		-f sim.f -o traceback_sim \
	&& ./obj_dir/traceback_sim \
	|| { echo "simulation did not pass"; exit 1; }

// ==== sim.f ====
+incdir+verilog
verilog/traceback_pkg.sv
verilog/traceback_fsm.sv
verilog/tile_loader.sv
verilog/tile_buffer.sv
verilog/move_decoder.sv
verilog/trace_cursor.sv
verilog/traceback_top.sv
testbench/traceback_assert.sv
testbench/traceback_tb.sv

// ==== testbench/traceback_assert.sv ====
`timescale 1ns/1ps

module traceback_assert (
	input logic clk,
	input logic rst_n,
	input logic col_req,
	input logic align_valid,
	input logic busy,
	input logic done
);

	// symbols only come out of an active walk
	valid_needs_busy: assert property (@(posedge clk) disable iff (!rst_n)
		align_valid |-> busy)
		else $error("align_valid high while busy is low");

	done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done held high for more than one cycle");

	// first edge after reset release
	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!busy && !done && !col_req && !align_valid))
		else $error("outputs not idle after reset");

endmodule

// ==== testbench/traceback_tb.sv ====
`timescale 1ns/1ps
`include "traceback_cfg.svh"

module traceback_tb;
	localparam int MAT_N = 32;
	localparam int N_CASES = 6;
	localparam int FIRST_SYM_CYCLE = 10; // capture plus a 9 cycle load
	localparam int RESTART_CYCLE = 16;
	// six walks of at most 64 moves and 16 reloads of 10 cycles each plus margin
	localparam int MAX_CYCLES = 2000;

	typedef struct {
		int sx;
		int sy;
		int fill;    // 0 diagonal, 1 random, 2 random with long gap runs
		int plant;   // nonzero plants an H stop word
		int px;
		int py;
		int restart; // nonzero sends a second start mid walk
	} case_t;

	logic                                        clk;
	logic                                        rst_n;
	logic                                        start;
	logic [`TB_POS_WIDTH-1:0]                    start_x;
	logic [`TB_POS_WIDTH-1:0]                    start_y;
	traceback_pkg::dir_word_u [`TB_TILE_LEN-1:0] col_data = '0;
	logic                                        col_req;
	logic [`TB_POS_WIDTH-1:0]                    col_addr;
	logic [`TB_POS_WIDTH-1:0]                    row_addr;
	traceback_pkg::move_t                        align_sym;
	logic                                        align_valid;
	logic                                        busy;
	logic                                        done;

	traceback_pkg::dir_word_u mat [MAT_N][MAT_N]; // [row x][column y]
	traceback_pkg::move_t     exp_q [$];
	case_t                    cases [N_CASES];
	int                       cycles = 0;

	traceback_top uut (
		.clk(clk), .rst_n(rst_n), .start(start), .start_x(start_x), .start_y(start_y),
		.col_data(col_data), .col_req(col_req), .col_addr(col_addr), .row_addr(row_addr),
		.align_sym(align_sym), .align_valid(align_valid), .busy(busy), .done(done)
	);

	bind traceback_top traceback_assert u_assert (
		.clk(clk), .rst_n(rst_n), .col_req(col_req),
		.align_valid(align_valid), .busy(busy), .done(done)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "run stopped at the first failed check");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			report_failure("timeout, the walks did not finish within the cycle limit");
	end

	// wrapped columns and cells outside the matrix read as stop words
	function automatic traceback_pkg::dir_word_u read_cell(input int x, input int y);
		if (x < 0 || y < 0 || x >= MAT_N || y >= MAT_N)
			return '0;
		return mat[x][y];
	endfunction

	// column memory with one cycle latency
	always @(posedge clk) begin
		if (col_req) begin
			for (int r = 0; r < `TB_TILE_LEN; r++)
				col_data[r] <= read_cell(int'(row_addr) - r, int'(col_addr));
		end
	end

	function automatic traceback_pkg::dir_word_u fill_word(input int mode);
		traceback_pkg::dir_word_u w;
		w.f.h_src = traceback_pkg::H_DIAG;
		w.f.i_ext = 1'b0;
		w.f.d_ext = 1'b0;
		if (mode != 0) begin
			w.f.h_src = traceback_pkg::h_src_t'(2'($urandom_range(3, 1))); // never stop
			if (mode == 1) begin
				w.f.i_ext = 1'($urandom_range(1, 0));
				w.f.d_ext = 1'($urandom_range(1, 0));
			end else begin
				w.f.i_ext = ($urandom_range(3, 0) != 0); // mostly extending
				w.f.d_ext = ($urandom_range(3, 0) != 0);
			end
		end
		return w;
	endfunction

	task automatic fill_matrix(input case_t c);
		traceback_pkg::dir_word_u stop_w;
		for (int x = 0; x < MAT_N; x++)
			for (int y = 0; y < MAT_N; y++)
				mat[x][y] = fill_word(c.fill);
		stop_w.f.h_src = traceback_pkg::H_STOP;
		stop_w.f.i_ext = 1'b1; // nonzero word so only the H state decode stops it
		stop_w.f.d_ext = 1'b1;
		if (c.plant != 0)
			mat[c.px][c.py] = stop_w;
	endtask

	// expected symbols from the traceback rules
	task automatic build_expected(input int sx, input int sy);
		int                       x;
		int                       y;
		bit                       go;
		traceback_pkg::move_t     prev;
		traceback_pkg::move_t     mv;
		traceback_pkg::dir_word_u w;
		x = sx;
		y = sy;
		go = 1'b1;
		prev = traceback_pkg::MOVE_NONE;
		exp_q.delete();
		while (go) begin
			w = mat[x][y];
			mv = traceback_pkg::MOVE_NONE;
			if (w.raw == '0)
				go = 1'b0;
			else if (prev == traceback_pkg::MOVE_I && w.f.i_ext)
				mv = traceback_pkg::MOVE_I;
			else if (prev == traceback_pkg::MOVE_D && w.f.d_ext)
				mv = traceback_pkg::MOVE_D;
			else if (w.f.h_src == traceback_pkg::H_DIAG)
				mv = traceback_pkg::MOVE_M;
			else if (w.f.h_src == traceback_pkg::H_FROM_I)
				mv = traceback_pkg::MOVE_I;
			else if (w.f.h_src == traceback_pkg::H_FROM_D)
				mv = traceback_pkg::MOVE_D;
			else
				go = 1'b0;
			if (x == 0 && (mv == traceback_pkg::MOVE_M || mv == traceback_pkg::MOVE_D))
				go = 1'b0;
			if (y == 0 && (mv == traceback_pkg::MOVE_M || mv == traceback_pkg::MOVE_I))
				go = 1'b0;
			if (go) begin
				exp_q.push_back(mv);
				x -= (mv != traceback_pkg::MOVE_I) ? 1 : 0;
				y -= (mv != traceback_pkg::MOVE_D) ? 1 : 0;
				prev = mv;
			end
		end
	endtask

	task automatic run_case(input case_t c);
		int n;
		int got;
		bit fin;
		fill_matrix(c);
		build_expected(c.sx, c.sy);
		n = 0;
		got = 0;
		fin = 1'b0;
		while (!fin) begin
			@(posedge clk);
			start <= (n == 0) || (c.restart != 0 && n == RESTART_CYCLE);
			if (n == 0) begin
				start_x <= 8'(c.sx);
				start_y <= 8'(c.sy);
			end else if (c.restart != 0 && n == RESTART_CYCLE) begin
				start_x <= 8'd3; // a different cell that must not be taken
				start_y <= 8'd3;
			end
			@(negedge clk);
			if (c.restart != 0 && n == RESTART_CYCLE)
				assert (busy) else report_failure("second start was not sent during a walk");
			if (align_valid) begin
				if (got == 0)
					assert (n == FIRST_SYM_CYCLE) else report_failure($sformatf(
						"** Error: first align_valid cycle = %h, expected %h", n, FIRST_SYM_CYCLE));
				assert (got < exp_q.size())
					else report_failure("a symbol came out after the expected walk had ended");
				assert (align_sym == exp_q[got]) else report_failure($sformatf(
					"** Error: align_sym = %h, expected %h", align_sym, exp_q[got]));
				got++;
			end
			// busy from the cycle after start until it falls with done
			if (done) begin
				assert (!busy) else report_failure($sformatf(
					"** Error: busy = %h at done, expected %h", busy, 1'b0));
			end else if (n > 0) begin
				assert (busy) else report_failure($sformatf(
					"** Error: busy = %h during the walk, expected %h", busy, 1'b1));
			end
			fin = done;
			n++;
		end
		assert (got == exp_q.size()) else report_failure($sformatf(
			"** Error: symbol count = %h, expected %h", got, exp_q.size()));
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		start_x = '0;
		start_y = '0;
		void'($urandom(32'h5a407909));
		cases[0] = '{5, 5, 0, 0, 0, 0, 0};     // one tile, ends at row 0
		cases[1] = '{20, 25, 1, 0, 0, 0, 0};   // several reloads
		cases[2] = '{28, 30, 2, 0, 0, 0, 0};   // long I and D runs
		cases[3] = '{21, 21, 0, 1, 12, 12, 0}; // stop after a reload
		cases[4] = '{0, 9, 0, 0, 0, 0, 0};     // no symbols
		cases[5] = '{18, 10, 1, 0, 0, 0, 1};   // start while busy
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < N_CASES; i++)
			run_case(cases[i]);
		repeat (2) @(posedge clk);
		$display("test passed");
		$finish;
	end

endmodule

// ==== verilog/move_decoder.sv ====
`timescale 1ns/1ps

module move_decoder (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     capture,
	input  logic                     step,
	input  traceback_pkg::dir_word_u rd_word,
	output traceback_pkg::move_t     next_move,
	output logic                     stop
);
	traceback_pkg::move_t       prev_move;
	traceback_pkg::dir_fields_t f;

	assign f = rd_word.f;

	always_comb begin
		stop = 1'b0;
		next_move = traceback_pkg::MOVE_NONE;
		// an open gap keeps going while the cell says it extends
		if (prev_move == traceback_pkg::MOVE_I && f.i_ext) begin
			next_move = traceback_pkg::MOVE_I;
		end else if (prev_move == traceback_pkg::MOVE_D && f.d_ext) begin
			next_move = traceback_pkg::MOVE_D;
		end else begin
			// back in H state
			case (f.h_src)
				traceback_pkg::H_DIAG:   next_move = traceback_pkg::MOVE_M;
				traceback_pkg::H_FROM_I: next_move = traceback_pkg::MOVE_I;
				traceback_pkg::H_FROM_D: next_move = traceback_pkg::MOVE_D;
				default:                 stop = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			prev_move <= traceback_pkg::MOVE_NONE;
		else if (capture)
			prev_move <= traceback_pkg::MOVE_NONE; // new walk starts in H
		else if (step)
			prev_move <= next_move;
	end

endmodule

// ==== verilog/tile_buffer.sv ====
`timescale 1ns/1ps
`include "traceback_cfg.svh"

module tile_buffer (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        wr_en,
	input  logic [`TB_OFF_WIDTH-1:0]                    wr_col,
	input  traceback_pkg::dir_word_u [`TB_TILE_LEN-1:0] col_data,
	input  logic [`TB_OFF_WIDTH-1:0]                    rd_row,
	input  logic [`TB_OFF_WIDTH-1:0]                    rd_col,
	output traceback_pkg::dir_word_u                    rd_word
);
	logic [`TB_DIR_WIDTH-1:0] mem [`TB_TILE_LEN][`TB_TILE_LEN]; // [row][col]
	logic [`TB_TILE_LEN-1:0]  col_vld;                          // column written since reset

	// word r is row origin_x-r, i.e. row offset TILE_LEN-1-r
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int r = 0; r < `TB_TILE_LEN; r++)
				mem[`TB_TILE_LEN - 1 - r][wr_col] <= col_data[r].raw;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			col_vld <= '0;
		else if (wr_en)
			col_vld[wr_col] <= 1'b1;
	end

	// an unwritten column reads as a stop word
	assign rd_word.raw = col_vld[rd_col] ? mem[rd_row][rd_col] : '0;

endmodule

// ==== verilog/tile_loader.sv ====
`timescale 1ns/1ps
`include "traceback_cfg.svh"

module tile_loader (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     load_go,
	input  logic [`TB_POS_WIDTH-1:0] origin_y,
	output logic                     col_req,
	output logic [`TB_POS_WIDTH-1:0] col_addr,
	output logic                     wr_en,
	output logic [`TB_OFF_WIDTH-1:0] wr_col,
	output logic                     load_done
);
	logic                     run; // columns 1..7 still pending
	logic [`TB_OFF_WIDTH-1:0] cnt; // in-tile column of this request

	// column 0 goes out in the load_go cycle itself
	assign col_req = load_go | run;

	// leftmost tile column is TILE_LEN-1 left of the origin, may wrap below zero
	assign col_addr = origin_y - `TB_POS_WIDTH'(`TB_TILE_LEN - 1) + `TB_POS_WIDTH'(cnt);

	// last column written
	assign load_done = wr_en && (wr_col == '1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			cnt <= '0;
		end else if (run) begin
			cnt <= cnt + `TB_OFF_WIDTH'(1); // wraps back to 0 after column 7
			if (cnt == '1)
				run <= 1'b0;
		end else if (load_go) begin
			run <= 1'b1;
			cnt <= `TB_OFF_WIDTH'(1);
		end
	end

	// memory answers one cycle after the request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_en <= 1'b0;
			wr_col <= '0;
		end else begin
			wr_en <= col_req;
			wr_col <= cnt;
		end
	end

endmodule

// ==== verilog/trace_cursor.sv ====
`timescale 1ns/1ps
`include "traceback_cfg.svh"

module trace_cursor (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     capture,
	input  logic                     walk_en,
	input  logic [`TB_POS_WIDTH-1:0] start_x,
	input  logic [`TB_POS_WIDTH-1:0] start_y,
	input  traceback_pkg::move_t     next_move,
	input  logic                     stop,
	input  traceback_pkg::dir_word_u rd_word,
	output logic [`TB_OFF_WIDTH-1:0] rd_row,
	output logic [`TB_OFF_WIDTH-1:0] rd_col,
	output logic [`TB_POS_WIDTH-1:0] origin_y,
	output logic [`TB_POS_WIDTH-1:0] row_addr,
	output traceback_pkg::move_t     align_sym,
	output logic                     align_valid,
	output logic                     step,
	output logic                     tile_exit,
	output logic                     walk_end
);
	logic [`TB_POS_WIDTH-1:0] pos_x;  // current cell row
	logic [`TB_POS_WIDTH-1:0] pos_y;  // current cell column
	logic [`TB_POS_WIDTH-1:0] org_x;  // bottom-right cell of the tile
	logic [`TB_POS_WIDTH-1:0] org_y;
	logic [`TB_OFF_WIDTH-1:0] off_x;  // row offset, TILE_LEN-1 at the origin
	logic [`TB_OFF_WIDTH-1:0] off_y;  // column offset
	logic [`TB_POS_WIDTH-1:0] nxt_x;
	logic [`TB_POS_WIDTH-1:0] nxt_y;
	logic                     dec_x;  // move steps up
	logic                     dec_y;  // move steps left
	logic                     hit_zero;

	always_comb begin
		dec_x = 1'b0;
		dec_y = 1'b0;
		case (next_move)
			traceback_pkg::MOVE_M: begin
				dec_x = 1'b1;
				dec_y = 1'b1;
			end
			traceback_pkg::MOVE_I: dec_y = 1'b1;
			traceback_pkg::MOVE_D: dec_x = 1'b1;
			default: ;
		endcase
	end

	assign nxt_x = pos_x - `TB_POS_WIDTH'(dec_x);
	assign nxt_y = pos_y - `TB_POS_WIDTH'(dec_y);

	// move would leave the matrix
	assign hit_zero = (dec_x && pos_x == '0) || (dec_y && pos_y == '0);

	// end of walk emits nothing
	assign walk_end = walk_en && (stop || rd_word.raw == '0 || hit_zero);
	assign step = walk_en && !walk_end;

	assign align_valid = step;
	assign align_sym = next_move;

	// offset about to go below zero, next cell lies outside the tile
	assign tile_exit = step && ((dec_x && off_x == '0) || (dec_y && off_y == '0));

	assign rd_row = off_x;
	assign rd_col = off_y;
	assign row_addr = org_x;
	assign origin_y = org_y;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos_x <= '0;
			pos_y <= '0;
			org_x <= '0;
			org_y <= '0;
			off_x <= '0;
			off_y <= '0;
		end else if (capture) begin
			pos_x <= start_x;
			pos_y <= start_y;
			org_x <= start_x;
			org_y <= start_y;
			off_x <= '1;
			off_y <= '1;
		end else if (step) begin
			pos_x <= nxt_x;
			pos_y <= nxt_y;
			if (tile_exit) begin
				// new tile anchored at the cell just reached
				org_x <= nxt_x;
				org_y <= nxt_y;
				off_x <= '1;
				off_y <= '1;
			end else begin
				off_x <= off_x - `TB_OFF_WIDTH'(dec_x);
				off_y <= off_y - `TB_OFF_WIDTH'(dec_y);
			end
		end
	end

endmodule

// ==== verilog/traceback_cfg.svh ====
`ifndef TRACEBACK_CFG_SVH
`define TRACEBACK_CFG_SVH

// tile edge, in cells (tile is square)
`define TB_TILE_LEN 8

// in-tile offset and column counter width, log2 of the tile edge
`define TB_OFF_WIDTH 3

// matrix coordinate width
`define TB_POS_WIDTH 8

// one direction word per matrix cell
`define TB_DIR_WIDTH 4

`endif

// ==== verilog/traceback_fsm.sv ====
`timescale 1ns/1ps

module traceback_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic load_done,
	input  logic tile_exit,
	input  logic walk_end,
	output logic load_go,
	output logic walk_en,
	output logic capture,
	output logic busy,
	output logic done
);
	traceback_pkg::phase_t state;
	traceback_pkg::phase_t state_nx;

	// idle and done count as not busy
	assign busy = !(state == traceback_pkg::PH_IDLE || state == traceback_pkg::PH_DONE);
	assign done = (state == traceback_pkg::PH_DONE);
	assign walk_en = (state == traceback_pkg::PH_WALK);

	// start cell is captured in the cycle start is accepted
	assign capture = start && !busy;

	always_comb begin
		state_nx = state;
		case (state)
			traceback_pkg::PH_IDLE,
			traceback_pkg::PH_DONE: begin
				state_nx = capture ? traceback_pkg::PH_LOAD : traceback_pkg::PH_IDLE;
			end
			traceback_pkg::PH_LOAD: begin
				if (load_done)
					state_nx = traceback_pkg::PH_WALK;
			end
			traceback_pkg::PH_WALK: begin
				if (walk_end)
					state_nx = traceback_pkg::PH_DONE;
				else if (tile_exit)
					state_nx = traceback_pkg::PH_DECIDE; // cursor already re-anchored
			end
			traceback_pkg::PH_DECIDE: state_nx = traceback_pkg::PH_LOAD;
			default: state_nx = traceback_pkg::PH_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= traceback_pkg::PH_IDLE;
			load_go <= 1'b0;
		end else begin
			state <= state_nx;
			// high in the first load cycle only
			load_go <= (state_nx == traceback_pkg::PH_LOAD) && (state != traceback_pkg::PH_LOAD);
		end
	end

endmodule

// ==== verilog/traceback_pkg.sv ====
`include "traceback_cfg.svh"

package traceback_pkg;

	// emitted alignment symbols
	typedef enum logic [1:0] {
		MOVE_M    = 2'd0, // diagonal, x-1 and y-1
		MOVE_I    = 2'd1, // column step left, y-1
		MOVE_D    = 2'd2, // row step up, x-1
		MOVE_NONE = 2'd3  // no move yet
	} move_t;

	// where the H value of a cell came from
	typedef enum logic [1:0] {
		H_STOP   = 2'd0,
		H_DIAG   = 2'd1,
		H_FROM_I = 2'd2,
		H_FROM_D = 2'd3
	} h_src_t;

	typedef struct packed {
		h_src_t h_src;
		logic   i_ext; // I at this cell extends a gap
		logic   d_ext; // D at this cell extends a gap
	} dir_fields_t;

	// same word seen raw or by fields
	typedef union packed {
		logic [`TB_DIR_WIDTH-1:0] raw;
		dir_fields_t              f;
	} dir_word_u;

	// controller phases
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_LOAD,
		PH_WALK,
		PH_DECIDE, // one cycle between tile exit and reload
		PH_DONE
	} phase_t;

endpackage

// ==== verilog/traceback_top.sv ====
`timescale 1ns/1ps
`include "traceback_cfg.svh"

module traceback_top (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          start,
	input  logic [`TB_POS_WIDTH-1:0]                      start_x,
	input  logic [`TB_POS_WIDTH-1:0]                      start_y,
	input  traceback_pkg::dir_word_u [`TB_TILE_LEN-1:0]   col_data,
	output logic                                          col_req,
	output logic [`TB_POS_WIDTH-1:0]                      col_addr,
	output logic [`TB_POS_WIDTH-1:0]                      row_addr,
	output traceback_pkg::move_t                          align_sym,
	output logic                                          align_valid,
	output logic                                          busy,
	output logic                                          done
);
	logic                     load_go;
	logic                     load_done;
	logic                     walk_en;
	logic                     capture;
	logic                     tile_exit;
	logic                     walk_end;
	logic                     wr_en;
	logic [`TB_OFF_WIDTH-1:0] wr_col;
	logic [`TB_OFF_WIDTH-1:0] rd_row;
	logic [`TB_OFF_WIDTH-1:0] rd_col;
	logic [`TB_POS_WIDTH-1:0] origin_y;
	logic                     step;
	logic                     stop;
	traceback_pkg::dir_word_u rd_word;
	traceback_pkg::move_t     next_move;

	traceback_fsm u_fsm (
		.clk(clk), .rst_n(rst_n), .start(start),
		.load_done(load_done), .tile_exit(tile_exit), .walk_end(walk_end),
		.load_go(load_go), .walk_en(walk_en), .capture(capture),
		.busy(busy), .done(done)
	);

	tile_loader u_loader (
		.clk(clk), .rst_n(rst_n), .load_go(load_go), .origin_y(origin_y),
		.col_req(col_req), .col_addr(col_addr),
		.wr_en(wr_en), .wr_col(wr_col), .load_done(load_done)
	);

	tile_buffer u_buffer (
		.clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_col(wr_col),
		.col_data(col_data), .rd_row(rd_row), .rd_col(rd_col), .rd_word(rd_word)
	);

	move_decoder u_decoder (
		.clk(clk), .rst_n(rst_n), .capture(capture), .step(step),
		.rd_word(rd_word), .next_move(next_move), .stop(stop)
	);

	trace_cursor u_cursor (
		.clk(clk), .rst_n(rst_n), .capture(capture), .walk_en(walk_en),
		.start_x(start_x), .start_y(start_y), .next_move(next_move),
		.stop(stop), .rd_word(rd_word), .rd_row(rd_row), .rd_col(rd_col),
		.origin_y(origin_y), .row_addr(row_addr), .align_sym(align_sym),
		.align_valid(align_valid), .step(step), .tile_exit(tile_exit),
		.walk_end(walk_end)
	);

endmodule
